// ==== rtl/rv_pkg.sv ====
// shared types and encodings for the rv32i integer execution core.
// only the opcodes listed here are decoded; everything else becomes a
// non-writing item with a zero result.

package rv_pkg;

	typedef logic [31:0] word_t;		// data word, register values and results.
	typedef logic [4:0]  reg_idx_t;		// register index, x0..x31.
	typedef logic [3:0]  alu_ctrl_t;	// alu operation select.
	typedef logic [6:0]  opcode_t;		// major opcode, instr[6:0].
	typedef logic [2:0]  func3_t;		// func3 field, instr[14:12].

	// alu operation codes.
	localparam alu_ctrl_t ALU_ADD    = 4'd0;
	localparam alu_ctrl_t ALU_SUB    = 4'd1;
	localparam alu_ctrl_t ALU_SLL    = 4'd2;
	localparam alu_ctrl_t ALU_SLT    = 4'd3;	// signed less than.
	localparam alu_ctrl_t ALU_SLTU   = 4'd4;	// unsigned less than.
	localparam alu_ctrl_t ALU_XOR    = 4'd5;
	localparam alu_ctrl_t ALU_SRL    = 4'd6;
	localparam alu_ctrl_t ALU_SRA    = 4'd7;
	localparam alu_ctrl_t ALU_OR     = 4'd8;
	localparam alu_ctrl_t ALU_AND    = 4'd9;
	localparam alu_ctrl_t ALU_PASS_B = 4'd10;	// used by lui.

	// rv32i major opcodes.
	localparam opcode_t OP_R     = 7'b0110011;
	localparam opcode_t OP_I     = 7'b0010011;
	localparam opcode_t OP_LUI   = 7'b0110111;
	localparam opcode_t OP_AUIPC = 7'b0010111;
	localparam opcode_t OP_S     = 7'b0100011;
	localparam opcode_t OP_B     = 7'b1100011;

	// branch compare kinds.
	localparam func3_t F3_BEQ  = 3'b000;
	localparam func3_t F3_BNE  = 3'b001;
	localparam func3_t F3_BLT  = 3'b100;
	localparam func3_t F3_BGE  = 3'b101;
	localparam func3_t F3_BLTU = 3'b110;
	localparam func3_t F3_BGEU = 3'b111;

endpackage

// ==== rtl/dec_ex_if.sv ====
// one decoded instruction on its way from decode to execute.
// every field is a registered decode output.

`timescale 1ns/10ps

interface dec_ex_if #(
	parameter int ADDR_WIDTH = 32	// program counter width.
);

	rv_pkg::word_t     rs1_data;	// source operand values.
	rv_pkg::word_t     rs2_data;
	rv_pkg::word_t     imm;		// sign-extended or upper immediate.
	rv_pkg::reg_idx_t  rd;
	logic [ADDR_WIDTH-1:0] pc;
	rv_pkg::alu_ctrl_t alu_ctrl;
	rv_pkg::func3_t    func3;
	rv_pkg::opcode_t   opcode;
	logic              valid;	// item holds a real instruction.

	// decode side writes the register.
	modport dec (
		output rs1_data, rs2_data, imm, rd, pc, alu_ctrl, func3, opcode, valid
	);

	// execute side only reads it.
	modport ex (
		input rs1_data, rs2_data, imm, rd, pc, alu_ctrl, func3, opcode, valid
	);

endinterface

// ==== rtl/reg_file.sv ====
// 32 x 32 register file, two combinational reads, one write.
// a write and a read of the same register in one cycle return the new
// value, so dependent instructions need no interlock. x0 always reads zero.

`timescale 1ns/10ps

module reg_file (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::reg_idx_t i_rs1,
	input  rv_pkg::reg_idx_t i_rs2,
	input  logic             i_wb_en,
	input  rv_pkg::reg_idx_t i_wb_rd,
	input  rv_pkg::word_t    i_wb_data,
	output rv_pkg::word_t    o_rs1_data,
	output rv_pkg::word_t    o_rs2_data
);

	rv_pkg::word_t regs [32];

	// a pending write to the same register wins over the stored value.
	function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t idx);
		if (idx == '0) return '0;	// x0 is hardwired.
		if (i_wb_en && (i_wb_rd == idx)) return i_wb_data;
		return regs[idx];
	endfunction

	assign o_rs1_data = read_port(i_rs1);
	assign o_rs2_data = read_port(i_rs2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (i_wb_en && (i_wb_rd != '0)) begin
			regs[i_wb_rd] <= i_wb_data;	// writes to x0 are dropped.
		end
	end

endmodule

// ==== rtl/decode.sv ====
// decode stage: register fields, immediate, alu control, pipeline register.
// i_stall high freezes the register and the input is not taken.
// an unsupported opcode gets an alu code with no operation, so its
// result reads zero in execute.

`timescale 1ns/10ps

module decode #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_pkg::word_t         i_instr,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_instr_valid,
	input  logic                  i_stall,
	input  rv_pkg::word_t         i_rs1_data,
	input  rv_pkg::word_t         i_rs2_data,
	output rv_pkg::reg_idx_t      o_rs1,
	output rv_pkg::reg_idx_t      o_rs2,
	dec_ex_if.dec                 dx
);

	rv_pkg::opcode_t   opcode;
	rv_pkg::func3_t    func3;
	rv_pkg::word_t     imm;
	rv_pkg::alu_ctrl_t alu_ctrl;
	logic              alt;	// instr[30], sub and sra select.

	assign opcode = i_instr[6:0];
	assign func3  = i_instr[14:12];
	assign alt    = i_instr[30];

	assign o_rs1 = i_instr[19:15];	// read addresses go straight to the rf.
	assign o_rs2 = i_instr[24:20];

	// immediate by instruction format.
	always_comb begin
		case (opcode)
			rv_pkg::OP_S:
				imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			rv_pkg::OP_B:
				imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
				       i_instr[30:25], i_instr[11:8], 1'b0};
			rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:
				imm = {i_instr[31:12], 12'd0};	// u-type.
			default:
				imm = {{20{i_instr[31]}}, i_instr[31:20]};	// i-type.
		endcase
	end

	// alu control.
	always_comb begin
		alu_ctrl = rv_pkg::alu_ctrl_t'(4'hf);	// no operation, result zero.
		case (opcode)
			rv_pkg::OP_R, rv_pkg::OP_I: begin
				case (func3)
					3'b000: alu_ctrl = (opcode == rv_pkg::OP_R && alt) ?
					                   rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;	// addi has no sub.
					3'b001: alu_ctrl = rv_pkg::ALU_SLL;
					3'b010: alu_ctrl = rv_pkg::ALU_SLT;
					3'b011: alu_ctrl = rv_pkg::ALU_SLTU;
					3'b100: alu_ctrl = rv_pkg::ALU_XOR;
					3'b101: alu_ctrl = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
					3'b110: alu_ctrl = rv_pkg::ALU_OR;
					default: alu_ctrl = rv_pkg::ALU_AND;
				endcase
			end
			rv_pkg::OP_B:     alu_ctrl = rv_pkg::ALU_SUB;
			rv_pkg::OP_LUI:   alu_ctrl = rv_pkg::ALU_PASS_B;
			rv_pkg::OP_S,
			rv_pkg::OP_AUIPC: alu_ctrl = rv_pkg::ALU_ADD;	// address or pc + imm.
			default: ;
		endcase
	end

	// decode to execute pipeline register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx.rs1_data <= '0;
			dx.rs2_data <= '0;
			dx.imm      <= '0;
			dx.rd       <= '0;
			dx.pc       <= '0;
			dx.alu_ctrl <= '0;
			dx.func3    <= '0;
			dx.opcode   <= '0;
			dx.valid    <= 1'b0;
		end else if (!i_stall) begin
			dx.rs1_data <= i_rs1_data;	// already forwarded by the rf.
			dx.rs2_data <= i_rs2_data;
			dx.imm      <= imm;
			dx.rd       <= i_instr[11:7];	// raw field, also for s and b.
			dx.pc       <= i_pc;
			dx.alu_ctrl <= alu_ctrl;
			dx.func3    <= func3;
			dx.opcode   <= opcode;
			dx.valid    <= i_instr_valid;
		end
	end

endmodule

// ==== rtl/alu.sv ====
// combinational 32-bit alu.
// shifts take the low 5 bits of operand 2; unknown codes give zero.

`timescale 1ns/10ps

module alu (
	input  rv_pkg::word_t     i_op1,
	input  rv_pkg::word_t     i_op2,
	input  rv_pkg::alu_ctrl_t i_alu_ctrl,
	output rv_pkg::word_t     o_result
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = i_op2[4:0];
	assign lt_s  = $signed(i_op1) < $signed(i_op2);
	assign lt_u  = i_op1 < i_op2;

	always_comb begin
		case (i_alu_ctrl)
			rv_pkg::ALU_ADD:    o_result = i_op1 + i_op2;
			rv_pkg::ALU_SUB:    o_result = i_op1 - i_op2;
			rv_pkg::ALU_SLL:    o_result = i_op1 << shamt;
			rv_pkg::ALU_SLT:    o_result = {31'd0, lt_s};
			rv_pkg::ALU_SLTU:   o_result = {31'd0, lt_u};
			rv_pkg::ALU_XOR:    o_result = i_op1 ^ i_op2;
			rv_pkg::ALU_SRL:    o_result = i_op1 >> shamt;
			rv_pkg::ALU_SRA:    o_result = $signed(i_op1) >>> shamt;	// sign fill.
			rv_pkg::ALU_OR:     o_result = i_op1 | i_op2;
			rv_pkg::ALU_AND:    o_result = i_op1 & i_op2;
			rv_pkg::ALU_PASS_B: o_result = i_op2;
			default:            o_result = '0;
		endcase
	end

endmodule

// ==== rtl/execute.sv ====
// execute stage: operand select, alu, branch compare, execute register.
// the register file write happens on the same enabled edge that this stage
// captures its item. a pc narrower than 32 bits is zero-extended.

`timescale 1ns/10ps

module execute #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_stall,
	dec_ex_if.ex                  dx,
	output rv_pkg::word_t         o_result,
	output rv_pkg::word_t         o_data_store,
	output logic [ADDR_WIDTH-1:0] o_pc,
	output rv_pkg::reg_idx_t      o_rd,
	output rv_pkg::func3_t        o_func3,
	output rv_pkg::opcode_t       o_opcode,
	output logic                  o_branch_taken,
	output logic                  o_ex_valid,
	output logic                  o_wb_en,
	output rv_pkg::reg_idx_t      o_wb_rd,
	output rv_pkg::word_t         o_wb_data
);

	rv_pkg::word_t op1;
	rv_pkg::word_t op2;
	rv_pkg::word_t alu_result;
	rv_pkg::word_t data_store;
	logic          taken;
	logic          writes_rd;	// opcode produces a register result.

	// operand muxes.
	always_comb begin
		if (dx.opcode == rv_pkg::OP_AUIPC) op1 = rv_pkg::word_t'(dx.pc);
		else if (dx.opcode == rv_pkg::OP_LUI) op1 = '0;
		else op1 = dx.rs1_data;
	end
	assign op2 = (dx.opcode == rv_pkg::OP_R || dx.opcode == rv_pkg::OP_B) ?
	             dx.rs2_data : dx.imm;

	alu alu_i (
		.i_op1     (op1),
		.i_op2     (op2),
		.i_alu_ctrl(dx.alu_ctrl),
		.o_result  (alu_result)
	);

	assign data_store = (dx.opcode == rv_pkg::OP_S) ? dx.rs2_data : '0;

	// branch decision, compared directly on the source values.
	always_comb begin
		taken = 1'b0;
		if (dx.opcode == rv_pkg::OP_B) begin
			case (dx.func3)
				rv_pkg::F3_BEQ:  taken = dx.rs1_data == dx.rs2_data;
				rv_pkg::F3_BNE:  taken = dx.rs1_data != dx.rs2_data;
				rv_pkg::F3_BLT:  taken = $signed(dx.rs1_data) < $signed(dx.rs2_data);
				rv_pkg::F3_BGE:  taken = $signed(dx.rs1_data) >= $signed(dx.rs2_data);
				rv_pkg::F3_BLTU: taken = dx.rs1_data < dx.rs2_data;
				rv_pkg::F3_BGEU: taken = dx.rs1_data >= dx.rs2_data;
				default:         taken = 1'b0;	// reserved func3.
			endcase
		end
	end

	// write-back fires with the capture edge only.
	assign writes_rd = (dx.opcode == rv_pkg::OP_R) || (dx.opcode == rv_pkg::OP_I) ||
	                   (dx.opcode == rv_pkg::OP_LUI) || (dx.opcode == rv_pkg::OP_AUIPC);
	assign o_wb_en   = !i_stall && dx.valid && writes_rd;
	assign o_wb_rd   = dx.rd;
	assign o_wb_data = alu_result;

	// execute to memory pipeline register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_result       <= '0;
			o_data_store   <= '0;
			o_pc           <= '0;
			o_rd           <= '0;
			o_func3        <= '0;
			o_opcode       <= '0;
			o_branch_taken <= 1'b0;
			o_ex_valid     <= 1'b0;
		end else if (!i_stall) begin
			o_result       <= alu_result;
			o_data_store   <= data_store;
			o_pc           <= dx.pc;
			o_rd           <= dx.rd;
			o_func3        <= dx.func3;
			o_opcode       <= dx.opcode;
			o_branch_taken <= taken;
			o_ex_valid     <= dx.valid;	// bubbles pass as invalid items.
		end
	end

endmodule

// ==== rtl/rv_exec_top.sv ====
// two-stage rv32i integer core: decode then execute.
// i_stall high freezes both stages; upstream must hold i_instr meanwhile.
// results appear two enabled edges after acceptance.

`timescale 1ns/10ps

module rv_exec_top #(
	parameter int ADDR_WIDTH = 32	// 32 or 16.
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_pkg::word_t         i_instr,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_instr_valid,
	input  logic                  i_stall,
	output rv_pkg::word_t         o_result,
	output rv_pkg::word_t         o_data_store,
	output logic [ADDR_WIDTH-1:0] o_pc,
	output rv_pkg::reg_idx_t      o_rd,
	output rv_pkg::func3_t        o_func3,
	output rv_pkg::opcode_t       o_opcode,
	output logic                  o_branch_taken,
	output logic                  o_ex_valid
);

	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::word_t    rs1_data;
	rv_pkg::word_t    rs2_data;
	logic             wb_en;
	rv_pkg::reg_idx_t wb_rd;
	rv_pkg::word_t    wb_data;

	dec_ex_if #(.ADDR_WIDTH(ADDR_WIDTH)) dx_if ();

	reg_file reg_file_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_rs1     (rs1),
		.i_rs2     (rs2),
		.i_wb_en   (wb_en),
		.i_wb_rd   (wb_rd),
		.i_wb_data (wb_data),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	decode #(.ADDR_WIDTH(ADDR_WIDTH)) decode_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_instr      (i_instr),
		.i_pc         (i_pc),
		.i_instr_valid(i_instr_valid),
		.i_stall      (i_stall),
		.i_rs1_data   (rs1_data),
		.i_rs2_data   (rs2_data),
		.o_rs1        (rs1),
		.o_rs2        (rs2),
		.dx           (dx_if.dec)
	);

	execute #(.ADDR_WIDTH(ADDR_WIDTH)) execute_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_stall       (i_stall),
		.dx            (dx_if.ex),
		.o_result      (o_result),
		.o_data_store  (o_data_store),
		.o_pc          (o_pc),
		.o_rd          (o_rd),
		.o_func3       (o_func3),
		.o_opcode      (o_opcode),
		.o_branch_taken(o_branch_taken),
		.o_ex_valid    (o_ex_valid),
		.o_wb_en       (wb_en),
		.o_wb_rd       (wb_rd),
		.o_wb_data     (wb_data)
	);

endmodule

// ==== bench/rv_exec_checker.sv ====
// assertions bound into the execute stage.
// covers reset and output hold during stalls.

`timescale 1ns/10ps

module rv_exec_checker (
	input logic        clk,
	input logic        rst_n,
	input logic        i_stall,
	input logic        o_ex_valid,
	input logic [31:0] o_result,
	input logic [31:0] o_data_store,
	input logic        o_branch_taken,
	input logic        o_wb_en
);

	// no valid output while reset is held.
	assert property (@(posedge clk) !rst_n |-> !o_ex_valid)
		else $error("execute output valid during reset");

	// a stalled edge leaves the execute register untouched.
	assert property (@(posedge clk) disable iff (!rst_n)
		i_stall |=> $stable(o_ex_valid) && $stable(o_result) &&
		            $stable(o_data_store) && $stable(o_branch_taken))
		else $error("execute outputs changed during a stall");

	// no register write while reset is held.
	assert property (@(posedge clk) !rst_n |-> !o_wb_en)
		else $error("write-back during reset");

endmodule

// ==== bench/rv_exec_tb.sv ====
// drives rv_exec_top with directed then random instructions, random stalls
// and input gaps, and checks it against a reference model with its own registers.
// runs at the default 32-bit pc width and stops at the first mismatch.

`timescale 1ns/10ps

module rv_exec_tb;

	localparam int ADDR_WIDTH = 32;
	localparam int NUM_INSTR  = 400;	// accepted instructions per run.
	localparam int PERIOD     = 100;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] data_store;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [2:0]  func3;
		logic [6:0]  opcode;
		logic        taken;
	} expect_t;

	logic                  clk;
	logic                  rst_n;
	logic [31:0]           i_instr;
	logic [ADDR_WIDTH-1:0] i_pc;
	logic                  i_instr_valid;
	logic                  i_stall;
	logic [31:0]           o_result;
	logic [31:0]           o_data_store;
	logic [ADDR_WIDTH-1:0] o_pc;
	logic [4:0]            o_rd;
	logic [2:0]            o_func3;
	logic [6:0]            o_opcode;
	logic                  o_branch_taken;
	logic                  o_ex_valid;

	expect_t     exp_q[$];	// expectations in acceptance order.
	logic [31:0] ref_regs [32];
	logic [31:0] directed[$];
	logic [31:0] rng_state;
	int          dir_idx;
	int          accepted;
	int          checked;

	rv_exec_top #(.ADDR_WIDTH(ADDR_WIDTH)) rv_exec_top_i (
		.clk(clk), .rst_n(rst_n), .i_instr(i_instr), .i_pc(i_pc),
		.i_instr_valid(i_instr_valid), .i_stall(i_stall),
		.o_result(o_result), .o_data_store(o_data_store), .o_pc(o_pc), .o_rd(o_rd),
		.o_func3(o_func3), .o_opcode(o_opcode), .o_branch_taken(o_branch_taken),
		.o_ex_valid(o_ex_valid)
	);

	bind execute rv_exec_checker rv_exec_checker_i (
		.clk(clk), .rst_n(rst_n), .i_stall(i_stall), .o_ex_valid(o_ex_valid),
		.o_result(o_result), .o_data_store(o_data_store),
		.o_branch_taken(o_branch_taken), .o_wb_en(o_wb_en)
	);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// instruction encoders in the standard rv32i field layout.
	function automatic logic [31:0] enc_r(logic [2:0] f3, logic alt, logic [4:0] rd,
	                                      logic [4:0] rs1, logic [4:0] rs2);
		return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_pkg::OP_R};
	endfunction
	function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
	                                      logic [11:0] imm);
		return {imm, rs1, f3, rd, rv_pkg::OP_I};
	endfunction
	function automatic logic [31:0] enc_u(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction
	function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_S};
	endfunction
	function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
	                                      logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_B};
	endfunction

	// legal random instruction with registers in x0..x7 for many dependencies.
	function automatic logic [31:0] rand_instr();
		logic [31:0] r;
		logic [31:0] v;
		logic [2:0]  f3;
		logic [2:0]  bf3 [6];
		int          kind;
		r    = lcg_next();
		v    = lcg_next();
		bf3  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		kind = int'(r[31:24]) % 6;
		f3   = r[10:8];
		case (kind)
			0: return enc_r(f3, (f3 == 3'd0 || f3 == 3'd5) && r[11], {2'b0, r[2:0]},
			                {2'b0, r[5:3]}, {2'b0, r[14:12]});
			1: begin
				if (f3 == 3'd1) return enc_i(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]}, {7'd0, v[4:0]});
				if (f3 == 3'd5) return enc_i(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]},
				                             {1'b0, r[11], 5'd0, v[4:0]});	// srli or srai.
				return enc_i(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]}, v[11:0]);
			end
			2: return enc_u(rv_pkg::OP_LUI, {2'b0, r[2:0]}, v[19:0]);
			3: return enc_u(rv_pkg::OP_AUIPC, {2'b0, r[2:0]}, v[19:0]);
			4: return enc_s({2'b0, r[5:3]}, {2'b0, r[14:12]}, v[11:0]);
			default: return enc_b(bf3[int'(r[23:16]) % 6], {2'b0, r[5:3]}, {2'b0, r[14:12]},
			                      {v[12:1], 1'b0});
		endcase
	endfunction

	function automatic logic [31:0] next_instr();
		if (dir_idx < directed.size()) begin
			dir_idx++;
			return directed[dir_idx-1];
		end
		return rand_instr();
	endfunction

	// reference model with rv32i semantics on its own register copy.
	function automatic void ref_accept(logic [31:0] instr, logic [31:0] pc);
		expect_t     e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] op2;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_u;
		logic        alt;
		logic        wr;
		a     = ref_regs[instr[19:15]];
		b     = ref_regs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		imm_u = {instr[31:12], 12'd0};
		alt   = instr[30];
		e     = '0;
		wr    = 1'b0;
		e.pc     = pc;
		e.rd     = instr[11:7];
		e.func3  = instr[14:12];
		e.opcode = instr[6:0];
		case (instr[6:0])
			rv_pkg::OP_R, rv_pkg::OP_I: begin
				wr  = 1'b1;
				op2 = (instr[6:0] == rv_pkg::OP_R) ? b : imm_i;
				case (instr[14:12])
					3'd0: e.result = (alt && instr[6:0] == rv_pkg::OP_R) ? a - op2 : a + op2;
					3'd1: e.result = a << op2[4:0];
					3'd2: e.result = {31'd0, $signed(a) < $signed(op2)};
					3'd3: e.result = {31'd0, a < op2};
					3'd4: e.result = a ^ op2;
					3'd5: e.result = alt ? $unsigned($signed(a) >>> op2[4:0]) : a >> op2[4:0];
					3'd6: e.result = a | op2;
					default: e.result = a & op2;
				endcase
			end
			rv_pkg::OP_LUI: begin
				wr       = 1'b1;
				e.result = imm_u;
			end
			rv_pkg::OP_AUIPC: begin
				wr       = 1'b1;
				e.result = pc + imm_u;
			end
			rv_pkg::OP_S: begin
				e.result     = a + imm_s;	// store address.
				e.data_store = b;
			end
			rv_pkg::OP_B: begin
				e.result = a - b;
				case (instr[14:12])
					3'b000: e.taken = a == b;
					3'b001: e.taken = a != b;
					3'b100: e.taken = $signed(a) < $signed(b);
					3'b101: e.taken = $signed(a) >= $signed(b);
					3'b110: e.taken = a < b;
					3'b111: e.taken = a >= b;
					default: e.taken = 1'b0;
				endcase
			end
			default: ;
		endcase
		if (wr && e.rd != 5'd0) ref_regs[e.rd] = e.result;	// x0 stays zero.
		exp_q.push_back(e);
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s item %0d: expected %h, actual %h", name, checked,
			         expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// each item is compared once on the falling edge before it moves on.
	always @(negedge clk) begin
		expect_t e;
		if (rst_n && o_ex_valid && !i_stall) begin
			if (exp_q.size() == 0) begin
				$display("Output valid with no instruction outstanding");
				$display("Something failed");
				$fatal(1);
			end
			e = exp_q.pop_front();
			check_value("result", e.result, o_result);
			check_value("data_store", e.data_store, o_data_store);
			check_value("pc", e.pc, 32'(o_pc));
			check_value("rd", 32'(e.rd), 32'(o_rd));
			check_value("func3", 32'(e.func3), 32'(o_func3));
			check_value("opcode", 32'(e.opcode), 32'(o_opcode));
			check_value("branch_taken", 32'(e.taken), 32'(o_branch_taken));
			checked++;
		end
	end

	initial begin
		#((NUM_INSTR * 20 + 20) * PERIOD);
		$display("Timeout: the pipeline did not finish all instructions in time");
		$display("Something failed");
		$fatal(1);
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		i_instr       = '0;
		i_pc          = '0;
		i_instr_valid = 1'b0;
		i_stall       = 1'b0;
		rng_state     = 32'h4c1d;
		dir_idx       = 0;
		accepted      = 0;
		checked       = 0;
		for (int i = 0; i < 32; i++) ref_regs[i] = '0;
		// x1 = -1 and x2 = 5 set up the shifts, compares and x0 writes that follow.
		directed = '{
			enc_i(3'd0, 5'd1, 5'd0, 12'hfff), enc_i(3'd0, 5'd2, 5'd0, 12'd5),
			enc_i(3'd1, 5'd3, 5'd1, 12'd0), enc_i(3'd1, 5'd4, 5'd2, 12'd31),
			enc_i(3'd5, 5'd5, 5'd1, 12'd31), enc_i(3'd5, 5'd6, 5'd1, 12'h41f),
			enc_r(3'd2, 1'b0, 5'd7, 5'd1, 5'd2), enc_r(3'd3, 1'b0, 5'd7, 5'd1, 5'd2),
			enc_i(3'd2, 5'd3, 5'd1, 12'd1), enc_i(3'd3, 5'd3, 5'd1, 12'd1),
			enc_r(3'd0, 1'b1, 5'd4, 5'd2, 5'd1), enc_r(3'd5, 1'b1, 5'd5, 5'd1, 5'd2),
			enc_i(3'd0, 5'd0, 5'd2, 12'd7), enc_r(3'd0, 1'b0, 5'd5, 5'd0, 5'd2),
			enc_u(rv_pkg::OP_LUI, 5'd6, 20'habcde), enc_u(rv_pkg::OP_AUIPC, 5'd7, 20'h12345),
			enc_s(5'd1, 5'd2, 12'd12), enc_b(3'b000, 5'd1, 5'd1, 13'd8),
			enc_b(3'b001, 5'd1, 5'd2, 13'd8), enc_b(3'b100, 5'd1, 5'd2, 13'd8),
			enc_b(3'b101, 5'd1, 5'd2, 13'd8), enc_b(3'b110, 5'd1, 5'd2, 13'd8),
			enc_b(3'b111, 5'd1, 5'd2, 13'd8)
		};
		repeat (5) @(posedge clk);
		rst_n   <= 1'b1;
		i_pc    <= lcg_next() & 32'hffff_fffc;
		i_instr <= next_instr();
		while (accepted < NUM_INSTR) begin
			@(posedge clk);
			if (!i_stall && i_instr_valid) begin
				ref_accept(i_instr, 32'(i_pc));	// taken at this edge.
				accepted++;
				i_instr <= next_instr();	// a gap keeps the same instruction on offer.
				i_pc    <= i_pc + 4;
			end
			if (!i_stall) begin	// a stalled edge holds everything on offer.
				i_instr_valid <= lcg_next() % 4 != 0;
			end
			i_stall <= lcg_next() % 4 == 0;
		end
		i_instr_valid <= 1'b0;
		i_stall       <= 1'b0;
		repeat (8) @(negedge clk);
		if (exp_q.size() == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("%0d instructions never reached the outputs", exp_q.size());
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

// ==== compile.f ====
rtl/rv_pkg.sv
rtl/dec_ex_if.sv
rtl/reg_file.sv
rtl/decode.sv
rtl/alu.sv
rtl/execute.sv
rtl/rv_exec_top.sv
bench/rv_exec_checker.sv
bench/rv_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_exec testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--top-module rv_exec_tb \
	-f compile.f \
	-o rv_exec_sim
./obj_dir/rv_exec_sim
